// File: rtl/s1c88_microcode.svh
`ifndef S1C88_MICROCODE_SVH
`define S1C88_MICROCODE_SVH

// micro ROM lookup
// field order is kind, src, dst, alu, flags, last
function automatic micro_t micro_rom(input uaddr_t ua);
    micro_t u;
    case (ua)
        UA_LD_BR_IMM:
            u = '{MICRO_MOVE, SRC_IMM_LO, REG_BR, ALU_PASS, 1'b0, 1'b1};
        UA_LD_A_MEM:
            u = '{MICRO_READ, SRC_IMM_LO, REG_A, ALU_PASS, 1'b0, 1'b1};
        UA_LD_B_A:
            u = '{MICRO_MOVE, SRC_A, REG_B, ALU_PASS, 1'b0, 1'b1};
        UA_LD_MEM_IMM:
            u = '{MICRO_WRITE, SRC_IMM_HI, REG_NONE, ALU_PASS, 1'b0, 1'b1};
        // read into ALU_A, then write back ALU_A | nn
        UA_OR_MEM_IMM:
            u = '{MICRO_READ, SRC_IMM_LO, REG_ALU_A, ALU_PASS, 1'b0, 1'b0};
        UA_OR_MEM_IMM + 5'd1:
            u = '{MICRO_WRITE, SRC_ALU, REG_NONE, ALU_OR, 1'b1, 1'b1};
        UA_LD_SC_IMM:
            u = '{MICRO_MOVE, SRC_IMM_LO, REG_SC, ALU_PASS, 1'b0, 1'b1};
        // A goes to ALU_A first for every A,#nn operation
        UA_ADD, UA_SUB, UA_AND, UA_OR, UA_XOR:
            u = '{MICRO_MOVE, SRC_A, REG_ALU_A, ALU_PASS, 1'b0, 1'b0};
        UA_ADD + 5'd1:
            u = '{MICRO_ALU, SRC_IMM_LO, REG_A, ALU_ADD, 1'b1, 1'b1};
        UA_SUB + 5'd1:
            u = '{MICRO_ALU, SRC_IMM_LO, REG_A, ALU_SUB, 1'b1, 1'b1};
        UA_AND + 5'd1:
            u = '{MICRO_ALU, SRC_IMM_LO, REG_A, ALU_AND, 1'b1, 1'b1};
        UA_OR + 5'd1:
            u = '{MICRO_ALU, SRC_IMM_LO, REG_A, ALU_OR, 1'b1, 1'b1};
        UA_XOR + 5'd1:
            u = '{MICRO_ALU, SRC_IMM_LO, REG_A, ALU_XOR, 1'b1, 1'b1};
        UA_ST_A:
            u = '{MICRO_WRITE, SRC_A, REG_NONE, ALU_PASS, 1'b0, 1'b1};
        UA_ST_B:
            u = '{MICRO_WRITE, SRC_B, REG_NONE, ALU_PASS, 1'b0, 1'b1};
        UA_ST_SC:
            u = '{MICRO_WRITE, SRC_SC, REG_NONE, ALU_PASS, 1'b0, 1'b1};
        // NOP and unused slots
        default:
            u = '{MICRO_MOVE, SRC_IMM_LO, REG_NONE, ALU_PASS, 1'b0, 1'b1};
    endcase
    return u;
endfunction

`endif

// File: rtl/s1c88_pkg.sv
package s1c88_pkg;

    typedef logic [15:0] addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;
    typedef logic [4:0]  uaddr_t;
    // bit0 Z, bit1 C, bit2 V, bit3 N
    typedef logic [3:0]  flags_t;

    localparam addr_t RESET_VECTOR_ADDR = 16'h0000;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_PASS
    } alu_op_e;

    typedef enum logic [2:0] {
        REG_NONE, REG_A, REG_B, REG_BR, REG_SC, REG_ALU_A
    } reg_sel_e;

    typedef enum logic [1:0] {
        MICRO_MOVE, MICRO_READ, MICRO_WRITE, MICRO_ALU
    } micro_kind_e;

    typedef enum logic [2:0] {
        SRC_IMM_LO, SRC_IMM_HI, SRC_A, SRC_B, SRC_SC, SRC_ALU
    } src_sel_e;

    typedef struct packed {
        micro_kind_e kind;
        src_sel_e    src;
        reg_sel_e    dst;
        alu_op_e     alu;
        logic        flags;
        logic        last;
    } micro_t;

    typedef enum logic [2:0] {
        DEC_VEC_LO, DEC_VEC_HI, DEC_OPCODE, DEC_OPERAND, DEC_PUSH
    } decode_state_e;

    typedef enum logic [1:0] {
        EX_IDLE, EX_RUN, EX_WAIT_READ
    } exec_state_e;

    localparam byte_t OP_LD_BR_IMM  = 8'hB4;
    localparam byte_t OP_LD_A_MEM   = 8'h44;
    localparam byte_t OP_LD_B_A     = 8'h48;
    localparam byte_t OP_LD_MEM_IMM = 8'hDD;
    localparam byte_t OP_OR_MEM_IMM = 8'hD9;
    localparam byte_t OP_LD_SC_IMM  = 8'h9F;
    localparam byte_t OP_ADD_IMM    = 8'h02;
    localparam byte_t OP_SUB_IMM    = 8'h12;
    localparam byte_t OP_AND_IMM    = 8'h22;
    localparam byte_t OP_OR_IMM     = 8'h2A;
    localparam byte_t OP_XOR_IMM    = 8'h3A;
    localparam byte_t OP_ST_A       = 8'h78;
    localparam byte_t OP_ST_B       = 8'h79;
    localparam byte_t OP_ST_SC      = 8'h7A;

    // micro ROM entry points, ALU entries take two slots
    localparam uaddr_t UA_NOP        = 5'd0;
    localparam uaddr_t UA_LD_BR_IMM  = 5'd1;
    localparam uaddr_t UA_LD_A_MEM   = 5'd2;
    localparam uaddr_t UA_LD_B_A     = 5'd3;
    localparam uaddr_t UA_LD_MEM_IMM = 5'd4;
    localparam uaddr_t UA_OR_MEM_IMM = 5'd5;
    localparam uaddr_t UA_LD_SC_IMM  = 5'd7;
    localparam uaddr_t UA_ADD        = 5'd8;
    localparam uaddr_t UA_SUB        = 5'd10;
    localparam uaddr_t UA_AND        = 5'd12;
    localparam uaddr_t UA_OR         = 5'd14;
    localparam uaddr_t UA_XOR        = 5'd16;
    localparam uaddr_t UA_ST_A       = 5'd18;
    localparam uaddr_t UA_ST_B       = 5'd19;
    localparam uaddr_t UA_ST_SC      = 5'd20;

endpackage

// File: rtl/s1c88_ifs.sv
`timescale 1ns/1ps

// decoded instructions, credit based flow control
interface instr_if;
    import s1c88_pkg::*;

    logic   valid;
    uaddr_t uaddr;
    // ll low, nn high
    word_t  imm;
    logic   credit;

    modport source (output valid, uaddr, imm, input credit);
    modport sink (input valid, uaddr, imm, output credit);
endinterface

// one requester port of the shared memory bus
interface bus_req_if;
    import s1c88_pkg::*;

    logic  req;
    addr_t addr;
    logic  write;
    byte_t wdata;
    // marks an opcode read for sync
    logic  opcode;
    logic  gnt;
    logic  rvalid;
    byte_t rdata;

    modport requester (output req, addr, write, wdata, opcode, input gnt, rvalid, rdata);
    modport target (input req, addr, write, wdata, opcode, output gnt, rvalid, rdata);
endinterface

// register file access from execute
interface reg_if;
    import s1c88_pkg::*;

    logic     wr_en;
    reg_sel_e wr_sel;
    byte_t    wr_data;
    logic     flags_en;
    flags_t   flags;
    byte_t    a;
    byte_t    b;
    byte_t    br;
    byte_t    sc;

    modport source (output wr_en, wr_sel, wr_data, flags_en, flags, input a, b, br, sc);
    modport target (input wr_en, wr_sel, wr_data, flags_en, flags, output a, b, br, sc);
endinterface

// File: rtl/s1c88_alu.sv
`timescale 1ns/1ps

module s1c88_alu (
    input  s1c88_pkg::alu_op_e op,
    input  s1c88_pkg::byte_t   a,
    input  s1c88_pkg::byte_t   b,
    output s1c88_pkg::byte_t   result,
    output s1c88_pkg::flags_t  flags
);
    import s1c88_pkg::*;

    // bit 8 holds carry or borrow, zero for logic ops
    logic [8:0] wide;
    logic       overflow;

    always_comb
    begin
        overflow = 1'b0;
        case (op)
            ALU_ADD:
            begin
                wide     = {1'b0, a} + {1'b0, b};
                overflow = (a[7] == b[7]) && (wide[7] != a[7]);
            end
            ALU_SUB:
            begin
                wide     = {1'b0, a} - {1'b0, b};
                overflow = (a[7] != b[7]) && (wide[7] != a[7]);
            end
            ALU_AND: wide = {1'b0, a & b};
            ALU_OR:  wide = {1'b0, a | b};
            ALU_XOR: wide = {1'b0, a ^ b};
            default: wide = {1'b0, b};
        endcase
        result = wide[7:0];
        // N V C Z
        flags  = {result[7], overflow, wide[8], result == 8'h00};
    end

endmodule

// File: rtl/s1c88_register_file.sv
`timescale 1ns/1ps

module s1c88_register_file (
    input logic   clk,
    input logic   reset,
    reg_if.target regs
);
    import s1c88_pkg::*;

    word_t ba;
    byte_t br;
    byte_t sc;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            ba <= '0;
            br <= '0;
            sc <= '0;
        end
        else
        begin
            if (regs.wr_en)
            begin
                case (regs.wr_sel)
                    REG_A:  ba[7:0]  <= regs.wr_data;
                    REG_B:  ba[15:8] <= regs.wr_data;
                    REG_BR: br       <= regs.wr_data;
                    REG_SC: sc       <= regs.wr_data;
                    default:
                    begin
                    end
                endcase
            end
            // flags only touch the low nibble of SC
            if (regs.flags_en)
                sc[3:0] <= regs.flags;
        end
    end

    assign regs.a  = ba[7:0];
    assign regs.b  = ba[15:8];
    assign regs.br = br;
    assign regs.sc = sc;

endmodule

// File: rtl/s1c88_bus_unit.sv
`timescale 1ns/1ps

module s1c88_bus_unit (
    input  logic             clk,
    input  logic             reset,
    bus_req_if.target        fetch,
    bus_req_if.target        data,
    input  s1c88_pkg::byte_t data_in,
    output s1c88_pkg::addr_t address_out,
    output s1c88_pkg::byte_t data_out,
    output logic             read,
    output logic             write,
    output logic             sync
);
    import s1c88_pkg::*;

    logic  use_data;
    logic  sel_write;
    logic  sel_opcode;
    addr_t sel_addr;
    byte_t sel_wdata;
    // owner of the read on the bus this cycle
    logic  read_owner_data;

    // data port has fixed priority
    assign use_data   = data.req;
    assign data.gnt   = data.req;
    assign fetch.gnt  = fetch.req && !data.req;

    assign sel_addr   = use_data ? data.addr : fetch.addr;
    assign sel_write  = use_data ? data.write : fetch.write;
    assign sel_wdata  = use_data ? data.wdata : fetch.wdata;
    assign sel_opcode = use_data ? data.opcode : fetch.opcode;

    // memory answers combinationally in the output cycle
    assign data.rvalid  = read && read_owner_data;
    assign fetch.rvalid = read && !read_owner_data;
    assign data.rdata   = data_in;
    assign fetch.rdata  = data_in;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            address_out     <= '0;
            data_out        <= '0;
            read            <= 1'b0;
            write           <= 1'b0;
            sync            <= 1'b0;
            read_owner_data <= 1'b0;
        end
        else if (data.req || fetch.req)
        begin
            address_out     <= sel_addr;
            data_out        <= sel_wdata;
            read            <= !sel_write;
            write           <= sel_write;
            sync            <= sel_opcode && !sel_write;
            read_owner_data <= use_data;
        end
        else
        begin
            read  <= 1'b0;
            write <= 1'b0;
            sync  <= 1'b0;
        end
    end

    // a fetch held back by a data access keeps its request and address
    assert property (@(posedge clk) disable iff (reset)
        fetch.req && !fetch.gnt |=> fetch.req && $stable(fetch.addr))
        else $error("fetch request dropped or changed before its grant");

endmodule

// File: rtl/s1c88_decode.sv
`timescale 1ns/1ps

module s1c88_decode #(
    parameter int INSTR_CREDITS = 2
) (
    input logic          clk,
    input logic          reset,
    bus_req_if.requester bus,
    instr_if.source      instr
);
    import s1c88_pkg::*;

    localparam int CW = $clog2(INSTR_CREDITS + 1);

    decode_state_e state;
    addr_t         pc;
    logic          pending;
    logic [CW-1:0] credits;
    logic [1:0]    ops_left;
    logic          op_hi;
    uaddr_t        uaddr;
    word_t         imm;
    // micro entry and operand byte count of the fetched opcode
    logic [6:0]    tr;

    always_comb
    begin
        case (bus.rdata)
            OP_LD_BR_IMM:  tr = {UA_LD_BR_IMM, 2'd1};
            OP_LD_A_MEM:   tr = {UA_LD_A_MEM, 2'd1};
            OP_LD_B_A:     tr = {UA_LD_B_A, 2'd0};
            OP_LD_MEM_IMM: tr = {UA_LD_MEM_IMM, 2'd2};
            OP_OR_MEM_IMM: tr = {UA_OR_MEM_IMM, 2'd2};
            OP_LD_SC_IMM:  tr = {UA_LD_SC_IMM, 2'd1};
            OP_ADD_IMM:    tr = {UA_ADD, 2'd1};
            OP_SUB_IMM:    tr = {UA_SUB, 2'd1};
            OP_AND_IMM:    tr = {UA_AND, 2'd1};
            OP_OR_IMM:     tr = {UA_OR, 2'd1};
            OP_XOR_IMM:    tr = {UA_XOR, 2'd1};
            OP_ST_A:       tr = {UA_ST_A, 2'd1};
            OP_ST_B:       tr = {UA_ST_B, 2'd1};
            OP_ST_SC:      tr = {UA_ST_SC, 2'd1};
            default:       tr = {UA_NOP, 2'd0};
        endcase
    end

    // one read in flight at a time, nothing fetched while waiting to push
    assign bus.req    = (state != DEC_PUSH) && !pending;
    assign bus.write  = 1'b0;
    assign bus.wdata  = '0;
    assign bus.opcode = (state == DEC_OPCODE);
    assign bus.addr   = (state == DEC_VEC_LO) ? RESET_VECTOR_ADDR
                      : (state == DEC_VEC_HI) ? RESET_VECTOR_ADDR + 16'd1
                      : pc;

    assign instr.valid = (state == DEC_PUSH) && (credits != '0);
    assign instr.uaddr = uaddr;
    assign instr.imm   = imm;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state    <= DEC_VEC_LO;
            pending  <= 1'b0;
            credits  <= CW'(INSTR_CREDITS);
            pc       <= '0;
            ops_left <= '0;
            op_hi    <= 1'b0;
            uaddr    <= UA_NOP;
            imm      <= '0;
        end
        else
        begin
            credits <= credits + CW'(instr.credit) - CW'(instr.valid);
            if (bus.rvalid)
                pending <= 1'b0;
            if (bus.gnt)
                pending <= 1'b1;

            case (state)
                DEC_VEC_LO:
                    if (bus.rvalid)
                    begin
                        pc[7:0] <= bus.rdata;
                        state   <= DEC_VEC_HI;
                    end
                DEC_VEC_HI:
                    if (bus.rvalid)
                    begin
                        pc[15:8] <= bus.rdata;
                        state    <= DEC_OPCODE;
                    end
                DEC_OPCODE:
                    if (bus.rvalid)
                    begin
                        pc       <= pc + 16'd1;
                        uaddr    <= tr[6:2];
                        ops_left <= tr[1:0];
                        op_hi    <= 1'b0;
                        imm      <= '0;
                        state    <= (tr[1:0] != 2'd0) ? DEC_OPERAND : DEC_PUSH;
                    end
                DEC_OPERAND:
                    if (bus.rvalid)
                    begin
                        // first operand byte lands in the low half
                        if (op_hi)
                            imm[15:8] <= bus.rdata;
                        else
                            imm[7:0] <= bus.rdata;
                        op_hi    <= 1'b1;
                        pc       <= pc + 16'd1;
                        ops_left <= ops_left - 2'd1;
                        if (ops_left == 2'd1)
                            state <= DEC_PUSH;
                    end
                default:
                    if (instr.valid)
                        state <= DEC_OPCODE;
            endcase
        end
    end

    // execute must never return more credits than it was given
    assert property (@(posedge clk) disable iff (reset) credits <= INSTR_CREDITS)
        else $error("decode credit count above INSTR_CREDITS");

endmodule

// File: rtl/s1c88_execute.sv
`timescale 1ns/1ps

module s1c88_execute #(
    parameter int INSTR_CREDITS = 2
) (
    input logic          clk,
    input logic          reset,
    instr_if.sink        instr,
    bus_req_if.requester bus,
    reg_if.source        regs
);
    import s1c88_pkg::*;
    `include "s1c88_microcode.svh"

    localparam int PW = (INSTR_CREDITS > 1) ? $clog2(INSTR_CREDITS) : 1;
    localparam int CW = $clog2(INSTR_CREDITS + 1);

    uaddr_t        q_uaddr [INSTR_CREDITS];
    word_t         q_imm [INSTR_CREDITS];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] q_count;
    exec_state_e   state;
    uaddr_t        step;
    byte_t         alu_a;
    micro_t        u;
    word_t         imm;
    byte_t         src_val;
    byte_t         alu_b;
    byte_t         alu_result;
    flags_t        alu_flags;
    logic          step_done;
    logic          retire;

    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
        return (p == PW'(INSTR_CREDITS - 1)) ? '0 : p + 1'b1;
    endfunction

    // current micro-op of the instruction at the queue head
    assign imm   = q_imm[rd_ptr];
    assign u     = micro_rom(q_uaddr[rd_ptr] + step);
    assign alu_b = (u.src == SRC_IMM_LO) ? imm[7:0] : imm[15:8];

    s1c88_alu alu (
        .op     (u.alu),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .flags  (alu_flags)
    );

    always_comb
    begin
        case (u.src)
            SRC_IMM_LO: src_val = imm[7:0];
            SRC_IMM_HI: src_val = imm[15:8];
            SRC_A:      src_val = regs.a;
            SRC_B:      src_val = regs.b;
            SRC_SC:     src_val = regs.sc;
            default:    src_val = alu_result;
        endcase
    end

    // data accesses always go to BR:ll
    assign bus.req    = (state == EX_RUN) && (u.kind == MICRO_READ || u.kind == MICRO_WRITE);
    assign bus.write  = (u.kind == MICRO_WRITE);
    assign bus.addr   = {regs.br, imm[7:0]};
    assign bus.wdata  = src_val;
    assign bus.opcode = 1'b0;

    assign step_done = (state == EX_RUN && (u.kind == MICRO_MOVE || u.kind == MICRO_ALU))
                    || (state == EX_RUN && u.kind == MICRO_WRITE && bus.gnt)
                    || (state == EX_WAIT_READ && bus.rvalid);
    assign retire    = step_done && u.last;

    assign regs.wr_sel   = u.dst;
    assign regs.wr_en    = step_done && u.kind != MICRO_WRITE
                        && u.dst != REG_NONE && u.dst != REG_ALU_A;
    assign regs.wr_data  = (state == EX_WAIT_READ) ? bus.rdata
                         : (u.kind == MICRO_ALU) ? alu_result
                         : src_val;
    assign regs.flags_en = step_done && u.flags;
    assign regs.flags    = alu_flags;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state        <= EX_IDLE;
            step         <= '0;
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            q_count      <= '0;
            instr.credit <= 1'b0;
        end
        else
        begin
            instr.credit <= retire;
            q_count      <= q_count + CW'(instr.valid) - CW'(retire);
            if (instr.valid)
                wr_ptr <= next_ptr(wr_ptr);

            case (state)
                EX_IDLE:
                    if (q_count != '0)
                        state <= EX_RUN;
                EX_RUN:
                    if (u.kind == MICRO_READ && bus.gnt)
                        state <= EX_WAIT_READ;
                default:
                    if (bus.rvalid)
                        state <= EX_RUN;
            endcase

            if (step_done)
            begin
                if (u.last)
                begin
                    // next instruction starts straight away if one is queued
                    step   <= '0;
                    rd_ptr <= next_ptr(rd_ptr);
                    state  <= (q_count > 1 || instr.valid) ? EX_RUN : EX_IDLE;
                end
                else
                    step <= step + 5'd1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (instr.valid)
        begin
            q_uaddr[wr_ptr] <= instr.uaddr;
            q_imm[wr_ptr]   <= instr.imm;
        end
        if (step_done && u.dst == REG_ALU_A)
            alu_a <= (state == EX_WAIT_READ) ? bus.rdata : src_val;
    end

    // decode only pushes while it holds a credit
    assert property (@(posedge clk) disable iff (reset)
        instr.valid |-> q_count < INSTR_CREDITS)
        else $error("instruction pushed into a full queue");

endmodule

// File: rtl/s1c88_core.sv
`timescale 1ns/1ps

module s1c88_core #(
    parameter int INSTR_CREDITS = 2
) (
    input  logic             clk,
    input  logic             reset,
    input  s1c88_pkg::byte_t data_in,
    output s1c88_pkg::addr_t address_out,
    output s1c88_pkg::byte_t data_out,
    output logic             read,
    output logic             write,
    output logic             sync
);

    instr_if   instr ();
    bus_req_if fetch_bus ();
    bus_req_if data_bus ();
    reg_if     regs ();

    // prefetch runs ahead of execute by up to INSTR_CREDITS instructions
    s1c88_decode #(
        .INSTR_CREDITS (INSTR_CREDITS)
    ) decode (
        .clk   (clk),
        .reset (reset),
        .bus   (fetch_bus),
        .instr (instr)
    );

    s1c88_execute #(
        .INSTR_CREDITS (INSTR_CREDITS)
    ) execute (
        .clk   (clk),
        .reset (reset),
        .instr (instr),
        .bus   (data_bus),
        .regs  (regs)
    );

    s1c88_register_file register_file (
        .clk   (clk),
        .reset (reset),
        .regs  (regs)
    );

    s1c88_bus_unit bus_unit (
        .clk         (clk),
        .reset       (reset),
        .fetch       (fetch_bus),
        .data        (data_bus),
        .data_in     (data_in),
        .address_out (address_out),
        .data_out    (data_out),
        .read        (read),
        .write       (write),
        .sync        (sync)
    );

endmodule

// File: verification/s1c88_tb.sv
`timescale 1ns/1ps

module s1c88_tb;

    // five tests at 600 cycles each
    localparam int MAX_CYCLES = 3000;
    localparam logic [15:0] PROG_BASE = 16'h0100;

    logic        clk;
    logic        reset;
    logic [7:0]  data_in;
    logic [15:0] address_out;
    logic [7:0]  data_out;
    logic        read;
    logic        write;
    logic        sync;

    logic [7:0]  mem [0:65535];
    logic [15:0] wr_addr_q [$];
    logic [7:0]  wr_data_q [$];
    logic [15:0] read_q [$];
    logic [15:0] sync_q [$];
    logic [15:0] load_ptr;
    integer      seed;
    int          errors;
    int          checks;
    int          cycles;

    s1c88_core #(
        .INSTR_CREDITS (2)
    ) dut (
        .clk         (clk),
        .reset       (reset),
        .data_in     (data_in),
        .address_out (address_out),
        .data_out    (data_out),
        .read        (read),
        .write       (write),
        .sync        (sync)
    );

    // memory answers combinationally while read is high
    assign data_in = read ? mem[address_out] : 8'h00;

    initial
    begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    // bus outputs sampled at the falling edge where they are stable
    always @(negedge clk)
    begin
        if (!reset)
        begin
            if (read)
                read_q.push_back(address_out);
            if (sync)
                sync_q.push_back(address_out);
            if (write)
            begin
                mem[address_out] = data_out;
                wr_addr_q.push_back(address_out);
                wr_data_q.push_back(data_out);
            end
        end
    end

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        checks = checks + 1;
        if (expected !== actual)
        begin
            errors = errors + 1;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic expect_write(input string name, input int idx, input logic [15:0] addr,
                                input logic [7:0] data);
        if (idx >= wr_addr_q.size())
        begin
            errors = errors + 1;
            $display("%s: memory write %0d never happened", name, idx);
        end
        else
        begin
            check_value({name, " write address"}, addr, wr_addr_q[idx]);
            check_value({name, " write data"}, {8'h00, data}, {8'h00, wr_data_q[idx]});
        end
    endtask

    // reset held while memory is cleared and the program is loaded
    task automatic begin_test();
        @(posedge clk);
        #1 reset = 1'b1;
        for (int i = 0; i < 65536; i++)
            mem[i] = 8'h00;
        wr_addr_q.delete();
        wr_data_q.delete();
        read_q.delete();
        sync_q.delete();
        mem[0] = PROG_BASE[7:0];
        mem[1] = PROG_BASE[15:8];
        load_ptr = PROG_BASE;
    endtask

    task automatic put(input logic [7:0] b);
        mem[load_ptr] = b;
        load_ptr = load_ptr + 16'd1;
    endtask

    task automatic run_until_writes(input int n);
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;
        while (wr_addr_q.size() < n)
            @(negedge clk);
    endtask

    // expected A and SC after an A,#nn operation with SC cleared by reset
    function automatic void alu_model(input logic [7:0] opc, input logic [7:0] a,
                                      input logic [7:0] n, output logic [7:0] res,
                                      output logic [7:0] sc);
        int   sa;
        int   sn;
        int   sres;
        logic c;
        logic v;
        sa = $signed(a);
        sn = $signed(n);
        c = 1'b0;
        v = 1'b0;
        case (opc)
            8'h02:
            begin
                res = a + n;
                c = (int'(a) + int'(n)) > 255;
                sres = sa + sn;
                v = (sres > 127) || (sres < -128);
            end
            8'h12:
            begin
                res = a - n;
                c = a < n;
                sres = sa - sn;
                v = (sres > 127) || (sres < -128);
            end
            8'h22: res = a & n;
            8'h2A: res = a | n;
            default: res = a ^ n;
        endcase
        sc = {4'h0, res[7], v, c, res == 8'h00};
    endfunction

    task automatic fetch_order();
        logic [15:0] exp_sync [5];
        exp_sync = '{16'h0100, 16'h0102, 16'h0103, 16'h0104, 16'h0106};
        begin_test();
        put(8'hB4);
        put(8'h20);
        // 0xFF is not a kept opcode and runs as a one byte NOP
        put(8'hFF);
        put(8'h48);
        put(8'h02);
        put(8'h05);
        put(8'h78);
        put(8'h40);
        run_until_writes(1);
        if (read_q.size() < 2)
        begin
            errors = errors + 1;
            $display("fetch_order: reset vector was not read");
        end
        else
        begin
            check_value("fetch_order vector low", 16'h0000, read_q[0]);
            check_value("fetch_order vector high", 16'h0001, read_q[1]);
        end
        if (sync_q.size() < 5)
        begin
            errors = errors + 1;
            $display("fetch_order: only %0d opcode fetches seen", sync_q.size());
        end
        else
        begin
            for (int i = 0; i < 5; i++)
                check_value($sformatf("fetch_order opcode %0d", i), exp_sync[i], sync_q[i]);
        end
        expect_write("fetch_order", 0, 16'h2040, 8'h05);
    endtask

    task automatic loads_and_stores();
        logic [7:0] v;
        v = 8'($random(seed));
        begin_test();
        mem[16'h3010] = v;
        put(8'hB4);
        put(8'h30);
        put(8'h44);
        put(8'h10);
        put(8'h48);
        put(8'h78);
        put(8'h20);
        put(8'h79);
        put(8'h21);
        run_until_writes(2);
        expect_write("loads_stores A", 0, 16'h3020, v);
        expect_write("loads_stores B", 1, 16'h3021, v);
    endtask

    task automatic alu_operations();
        logic [7:0] ops [5];
        logic [7:0] a;
        logic [7:0] n;
        logic [7:0] res;
        logic [7:0] sc;
        ops = '{8'h02, 8'h12, 8'h22, 8'h2A, 8'h3A};
        for (int i = 0; i < 5; i++)
        begin
            a = 8'($random(seed));
            n = 8'($random(seed));
            begin_test();
            mem[16'h4000] = a;
            put(8'hB4);
            put(8'h40);
            put(8'h44);
            put(8'h00);
            put(ops[i]);
            put(n);
            put(8'h78);
            put(8'h01);
            put(8'h7A);
            put(8'h02);
            run_until_writes(2);
            alu_model(ops[i], a, n, res, sc);
            expect_write($sformatf("alu_%h result", ops[i]), 0, 16'h4001, res);
            expect_write($sformatf("alu_%h flags", ops[i]), 1, 16'h4002, sc);
        end
    endtask

    task automatic read_modify_write();
        logic [7:0] v;
        logic [7:0] n;
        logic [7:0] res;
        v = 8'($random(seed));
        n = 8'($random(seed));
        res = v | n;
        begin_test();
        mem[16'h5010] = v;
        put(8'hB4);
        put(8'h50);
        put(8'hD9);
        put(8'h10);
        put(n);
        put(8'h7A);
        put(8'h11);
        run_until_writes(2);
        expect_write("rmw result", 0, 16'h5010, res);
        expect_write("rmw flags", 1, 16'h5011, {4'h0, res[7], 2'b00, res == 8'h00});
    endtask

    task automatic immediate_stores();
        logic [7:0] n1;
        logic [7:0] n2;
        n1 = 8'($random(seed));
        n2 = 8'($random(seed));
        begin_test();
        put(8'hB4);
        put(8'h60);
        put(8'hDD);
        put(8'h05);
        put(n1);
        put(8'h9F);
        put(n2);
        put(8'h7A);
        put(8'h06);
        run_until_writes(2);
        expect_write("immediate store", 0, 16'h6005, n1);
        expect_write("sc load", 1, 16'h6006, n2);
    endtask

    initial
    begin
        seed = 5295;
        errors = 0;
        checks = 0;
        cycles = 0;
        reset = 1'b1;
        load_ptr = PROG_BASE;
        for (int i = 0; i < 65536; i++)
            mem[i] = 8'h00;

        fetch_order();
        loads_and_stores();
        alu_operations();
        read_modify_write();
        immediate_stores();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// File: src.f
+incdir+rtl
rtl/s1c88_pkg.sv
rtl/s1c88_ifs.sv
rtl/s1c88_alu.sv
rtl/s1c88_register_file.sv
rtl/s1c88_bus_unit.sv
rtl/s1c88_decode.sv
rtl/s1c88_execute.sv
rtl/s1c88_core.sv
verification/s1c88_tb.sv

// File: run.sh
#!/bin/sh
# build and run the s1c88 testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module s1c88_tb -o s1c88_sim

./obj_dir/s1c88_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
exit 0
